// File: all.f
hdl/mem_cache_pkg.sv
hdl/req_latch.sv
hdl/dcache_array.sv
hdl/mem_port.sv
hdl/cache_ctrl.sv
hdl/mem_cache_top.sv
test/tb_mem_model.sv
test/tb_mem_cache.sv

// File: run.sh
#!/bin/sh
# Build the data cache testbench with Verilator, run it and check the log

LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mem_cache -f all.f -o tb_mem_cache
if [ $? -ne 0 ]; then
    echo "run.sh: Verilator build failed"
    exit 1
fi

./obj_dir/tb_mem_cache > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "run.sh: simulation failed"
    exit 1
fi
if [ $sim_status -ne 0 ] || ! grep -q "NO ERRORS" "$LOG"; then
    echo "run.sh: simulation did not finish cleanly"
    exit 1
fi
echo "run.sh: simulation passed"
exit 0

// File: test/tb_mem_cache.sv
// Testbench for the write-through data cache
// directed and random loads/stores against a shadow byte memory,
// with a check of every memory strobe and every returned line
`timescale 1ns/1ps
`default_nettype none

module tb_mem_cache
    import mem_cache_pkg::*;
();

    localparam int CACHE_LINES = 64;
    localparam int IDX_W       = $clog2(CACHE_LINES);
    localparam int PERIOD      = 8;
    localparam int MAX_DELAY   = 6;
    localparam int N_DIRECTED  = 16;
    localparam int N_RAND      = 300;
    localparam int REQ_CYCLES  = 2 * (MAX_DELAY + 8);      // store drain, then a fill
    localparam int WATCHDOG_CYCLES =
        (N_DIRECTED + N_RAND) * REQ_CYCLES + CACHE_LINES + 16 + 64;

    logic              CLK = 1'b0;
    logic              rrst_x;
    logic              rd_en;
    logic              wr_en;
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] wdata;
    size_e             size;
    line_t             rdata;
    logic              busy;
    logic              mem_rd;
    logic              mem_wr;
    logic [ADDR_W-1:0] mem_addr;
    logic [WORD_W-1:0] mem_wdata;
    logic [3:0]        mem_mask;
    line_t             mem_rdata;
    logic              mem_busy;

    logic [7:0]        shadow [logic [ADDR_W-1:0]];   // bytes written so far
    logic [ADDR_W-5:0] line_tag [CACHE_LINES];         // line number held per index
    logic              line_ok  [CACHE_LINES];
    logic [68:0]       exp_ops [$];                    // {wr, addr, mask, word}
    line_t             held_line;
    string             test_name;
    event              data_check;

    always #(PERIOD / 2) CLK = ~CLK;

    mem_cache_top #(
        .CACHE_LINES (CACHE_LINES)
    ) i_dut (
        .CLK         (CLK),
        .i_rrst_x    (rrst_x),
        .i_rd_en     (rd_en),
        .i_wr_en     (wr_en),
        .i_addr      (addr),
        .i_data      (wdata),
        .i_size      (size),
        .o_data      (rdata),
        .o_busy      (busy),
        .o_mem_rd    (mem_rd),
        .o_mem_wr    (mem_wr),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata),
        .o_mem_mask  (mem_mask),
        .i_mem_rdata (mem_rdata),
        .i_mem_busy  (mem_busy)
    );

    tb_mem_model #(
        .MAX_DELAY (MAX_DELAY)
    ) u_mem (
        .CLK         (CLK),
        .i_rrst_x    (rrst_x),
        .i_mem_rd    (mem_rd),
        .i_mem_wr    (mem_wr),
        .i_mem_addr  (mem_addr),
        .i_mem_wdata (mem_wdata),
        .i_mem_mask  (mem_mask),
        .o_mem_rdata (mem_rdata),
        .o_mem_busy  (mem_busy)
    );

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "run aborted");
    endtask

    // same default contents as the memory model
    function automatic logic [7:0] fill_byte(input logic [ADDR_W-1:0] a);
        logic [ADDR_W-1:0] h;
        h = a * 32'h9e37_79b1;
        return h[31:24];
    endfunction

    function automatic logic [7:0] shadow_byte(input logic [ADDR_W-1:0] a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return fill_byte(a);
    endfunction

    // expected line for any address in it
    function automatic line_t ref_line(input logic [ADDR_W-1:0] a);
        line_t             r;
        logic [ADDR_W-1:0] base;
        base = {a[ADDR_W-1:4], 4'h0};
        for (int i = 0; i < LINE_BYTES; i++) begin
            r.bytes[i] = shadow_byte(base + ADDR_W'(i));
        end
        return r;
    endfunction

    function automatic logic [3:0] store_mask(input logic [1:0] lo, input size_e sz);
        case (sz)
            SZ_BYTE: return 4'b0001 << lo;
            SZ_HALF: return lo[1] ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [WORD_W-1:0] store_word(input logic [WORD_W-1:0] d,
                                                     input size_e sz);
        case (sz)
            SZ_BYTE: return {4{d[7:0]}};
            SZ_HALF: return {2{d[15:0]}};
            default: return d;
        endcase
    endfunction

    function automatic logic is_cached(input logic [ADDR_W-1:0] a);
        return line_ok[a[4 +: IDX_W]] && (line_tag[a[4 +: IDX_W]] == a[ADDR_W-1:4]);
    endfunction

    // four tags over eight indices, so lines keep evicting each other
    function automatic logic [ADDR_W-1:0] rand_addr();
        logic [ADDR_W-1:0] a;
        a        = 32'h0000_4000;
        a[11:10] = 2'($urandom_range(3));
        a[6:4]   = 3'($urandom_range(7));
        a[3:0]   = 4'($urandom_range(15));
        return a;
    endfunction

    task automatic wait_idle(output int lat);
        lat = 0;
        while (busy !== 1'b0) begin
            @(negedge CLK);
            lat++;
            assert (lat <= REQ_CYCLES) else begin
                $display("%s: request did not complete within %0d cycles",
                         test_name, REQ_CYCLES);
                abort_run();
            end
        end
    endtask

    task automatic do_read(input logic [ADDR_W-1:0] a);
        logic hit;
        int   lat;
        hit = is_cached(a);
        if (!hit) begin
            exp_ops.push_back({1'b0, a[ADDR_W-1:4], 4'h0, 4'b0000, 32'h0});
        end
        addr  = a;
        rd_en = 1'b1;
        @(negedge CLK);
        rd_en = 1'b0;
        assert (busy === 1'b1) else begin
            $display("%s: busy did not rise after a read was accepted", test_name);
            abort_run();
        end
        wait_idle(lat);
        if (hit) begin
            assert (lat == 2) else begin
                $display("ERR %s: expected %0d, actual %0d", test_name, 2, lat);
                abort_run();
            end
        end else begin
            assert (exp_ops.size() == 0) else begin
                $display("%s: expected memory read was not issued", test_name);
                abort_run();
            end
            line_ok[a[4 +: IDX_W]]  = 1'b1;          // read miss allocates
            line_tag[a[4 +: IDX_W]] = a[ADDR_W-1:4];
        end
        held_line = ref_line(a);
        -> data_check;
    endtask

    task automatic do_store(input logic [ADDR_W-1:0] a, input logic [WORD_W-1:0] d,
                            input size_e sz);
        logic [3:0]        m;
        logic [WORD_W-1:0] w;
        int                lat;
        m = store_mask(a[1:0], sz);
        w = store_word(d, sz);
        exp_ops.push_back({1'b1, a[ADDR_W-1:2], 2'b00, m, w});
        addr  = a;
        wdata = d;
        size  = sz;
        wr_en = 1'b1;
        @(negedge CLK);
        wr_en = 1'b0;
        assert (busy === 1'b1) else begin
            $display("%s: busy did not rise after a store was accepted", test_name);
            abort_run();
        end
        wait_idle(lat);
        assert (exp_ops.size() == 0) else begin
            $display("%s: expected memory write was not issued", test_name);
            abort_run();
        end
        for (int b = 0; b < 4; b++) begin
            if (m[b]) begin
                shadow[{a[ADDR_W-1:2], 2'(b)}] = w[8*b +: 8];
            end
        end
        -> data_check;                                // o_data must not move
    endtask

    // every memory strobe must match the oldest expected access
    always @(negedge CLK) begin
        logic [68:0] op;
        logic [68:0] got;
        if (mem_rd === 1'b1 || mem_wr === 1'b1) begin
            assert (exp_ops.size() != 0) else begin
                $display("%s: memory strobe seen with no access expected", test_name);
                abort_run();
            end
            op  = exp_ops.pop_front();
            got = {mem_wr, mem_addr, mem_wr ? mem_mask : 4'b0000,
                   mem_wr ? mem_wdata : 32'h0};
            assert (got == op) else begin
                $display("ERR %s: expected %h, actual %h", test_name, op, got);
                abort_run();
            end
        end
    end

    always @(data_check) begin
        assert (rdata == held_line) else begin
            $display("ERR %s: expected %h, actual %h", test_name, held_line, rdata);
            abort_run();
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("watchdog expired before the tests finished");
        abort_run();
    end

    initial begin
        logic [ADDR_W-1:0] a;
        int                lat;
        void'($urandom(32'hdf3d));
        rrst_x    = 1'b0;
        rd_en     = 1'b0;
        wr_en     = 1'b0;
        addr      = '0;
        wdata     = '0;
        size      = SZ_WORD;
        held_line = '0;
        for (int i = 0; i < CACHE_LINES; i++) begin
            line_ok[i]  = 1'b0;
            line_tag[i] = '0;
        end

        test_name = "reset";
        repeat (16) @(negedge CLK);
        rrst_x = 1'b1;
        lat    = 0;
        while (busy !== 1'b0) begin
            @(negedge CLK);
            lat++;
            assert (lat <= CACHE_LINES + 4) else begin
                $display("busy stayed high after the reset sweep");
                abort_run();
            end
        end

        test_name = "first_read";
        do_read(32'h0000_0100);
        test_name = "repeat_read";
        do_read(32'h0000_0104);
        test_name = "store_byte";
        do_store(32'h0000_0105, 32'h0000_00a5, SZ_BYTE);
        do_read(32'h0000_0100);
        test_name = "store_half";
        do_store(32'h0000_010a, 32'h0000_beef, SZ_HALF);
        do_read(32'h0000_0108);
        test_name = "store_word";
        do_store(32'h0000_010c, 32'h1234_5678, SZ_WORD);
        do_read(32'h0000_0100);
        test_name = "store_miss";
        do_store(32'h0000_2204, 32'hcafe_f00d, SZ_WORD);
        do_store(32'h0000_2213, 32'h0000_003c, SZ_BYTE);
        do_read(32'h0000_2200);
        test_name = "evict";
        do_read(32'h0000_0500);                       // same index as 0x100
        do_read(32'h0000_0100);

        test_name = "random_mix";
        for (int n = 0; n < N_RAND; n++) begin
            a = rand_addr();
            if ($urandom_range(1) == 0) begin
                do_read(a);
            end else begin
                case ($urandom_range(2))
                    0: do_store(a, $urandom(), SZ_BYTE);
                    1: do_store({a[ADDR_W-1:1], 1'b0}, $urandom(), SZ_HALF);
                    default: do_store({a[ADDR_W-1:2], 2'b00}, $urandom(), SZ_WORD);
                endcase
            end
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/tb_mem_model.sv
// Line memory model for the data cache testbench
// answers read and write strobes after a random busy time
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model
    import mem_cache_pkg::*;
#(
    parameter int MAX_DELAY = 6
) (
    input  wire               CLK,
    input  wire               i_rrst_x,
    input  wire               i_mem_rd,
    input  wire               i_mem_wr,
    input  wire [ADDR_W-1:0]  i_mem_addr,
    input  wire [WORD_W-1:0]  i_mem_wdata,
    input  wire [3:0]         i_mem_mask,
    output line_t             o_mem_rdata,
    output logic              o_mem_busy
);

    logic [7:0] bytes_q [logic [ADDR_W-1:0]];        // only written bytes are kept
    int         wait_cnt;

    // untouched memory reads back a hash of the full address
    function automatic logic [7:0] fill_byte(input logic [ADDR_W-1:0] a);
        logic [ADDR_W-1:0] h;
        h = a * 32'h9e37_79b1;
        return h[31:24];
    endfunction

    function automatic logic [7:0] read_byte(input logic [ADDR_W-1:0] a);
        if (bytes_q.exists(a)) begin
            return bytes_q[a];
        end
        return fill_byte(a);
    endfunction

    initial begin
        o_mem_rdata = '0;
        o_mem_busy  = 1'b0;
        wait_cnt    = 0;
        forever begin
            @(negedge CLK);                           // outputs move on the falling edge
            if (!i_rrst_x) begin
                o_mem_busy = 1'b0;
                wait_cnt   = 0;
            end else if (i_mem_rd === 1'b1 || i_mem_wr === 1'b1) begin
                wait_cnt   = $urandom_range(MAX_DELAY);   // zero means busy never rises
                o_mem_busy = (wait_cnt != 0);
                if (i_mem_wr) begin
                    for (int b = 0; b < 4; b++) begin
                        if (i_mem_mask[b]) begin
                            bytes_q[i_mem_addr + ADDR_W'(b)] = i_mem_wdata[8*b +: 8];
                        end
                    end
                end else begin
                    for (int i = 0; i < LINE_BYTES; i++) begin
                        o_mem_rdata.bytes[i] = read_byte(i_mem_addr + ADDR_W'(i));
                    end
                end
            end else if (wait_cnt != 0) begin
                wait_cnt--;
                o_mem_busy = (wait_cnt != 0);         // line stays valid after this
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/mem_cache_top.sv
// Write-through data cache top level
// request stage, cache array, memory port and controller
`timescale 1ns/1ps
`default_nettype none

module mem_cache_top
    import mem_cache_pkg::*;
#(
    parameter int CACHE_LINES = 64
) (
    input  wire               CLK,
    input  wire               i_rrst_x,
    input  wire               i_rd_en,
    input  wire               i_wr_en,
    input  wire [ADDR_W-1:0]  i_addr,
    input  wire [WORD_W-1:0]  i_data,
    input  wire size_e        i_size,
    output line_t             o_data,
    output logic              o_busy,
    output logic              o_mem_rd,
    output logic              o_mem_wr,
    output logic [ADDR_W-1:0] o_mem_addr,
    output logic [WORD_W-1:0] o_mem_wdata,
    output logic [3:0]        o_mem_mask,
    input  wire line_t        i_mem_rdata,
    input  wire               i_mem_busy
);

    logic              w_rd;
    logic              w_wr;
    logic [ADDR_W-1:0] w_addr;
    logic [WORD_W-1:0] w_wword;
    logic [3:0]        w_wmask;
    logic              w_hit;
    line_t             w_rline;
    logic              w_sweep;
    logic              w_stall;
    line_t             w_fill_line;
    logic [ADDR_W-1:0] w_arr_addr;
    logic              w_arr_we;
    line_t             w_arr_wline;
    logic              w_fill;
    logic              w_store;

    req_latch u_req (
        .CLK      (CLK),
        .i_rrst_x (i_rrst_x),
        .i_rd_en  (i_rd_en),
        .i_wr_en  (i_wr_en),
        .i_addr   (i_addr),
        .i_data   (i_data),
        .i_size   (i_size),
        .i_busy   (o_busy),
        .o_rd     (w_rd),
        .o_wr     (w_wr),
        .o_addr   (w_addr),
        .o_wword  (w_wword),
        .o_wmask  (w_wmask)
    );

    dcache_array #(
        .CACHE_LINES (CACHE_LINES)
    ) u_array (
        .CLK      (CLK),
        .i_rrst_x (i_rrst_x),
        .i_addr   (w_arr_addr),
        .i_we     (w_arr_we),
        .i_wline  (w_arr_wline),
        .o_rline  (w_rline),
        .o_hit    (w_hit),
        .o_sweep  (w_sweep)
    );

    mem_port u_port (
        .CLK         (CLK),
        .i_rrst_x    (i_rrst_x),
        .i_fill      (w_fill),
        .i_store     (w_store),
        .i_addr      (w_addr),
        .i_wword     (w_wword),
        .i_wmask     (w_wmask),
        .o_stall     (w_stall),
        .o_fill_line (w_fill_line),
        .o_mem_rd    (o_mem_rd),
        .o_mem_wr    (o_mem_wr),
        .o_mem_addr  (o_mem_addr),
        .o_mem_wdata (o_mem_wdata),
        .o_mem_mask  (o_mem_mask),
        .i_mem_rdata (i_mem_rdata),
        .i_mem_busy  (i_mem_busy)
    );

    cache_ctrl u_ctrl (
        .CLK         (CLK),
        .i_rrst_x    (i_rrst_x),
        .i_rd        (w_rd),
        .i_wr        (w_wr),
        .i_addr      (w_addr),
        .i_wword     (w_wword),
        .i_wmask     (w_wmask),
        .i_hit       (w_hit),
        .i_rline     (w_rline),
        .i_sweep     (w_sweep),
        .i_stall     (w_stall),
        .i_fill_line (w_fill_line),
        .o_arr_addr  (w_arr_addr),
        .o_arr_we    (w_arr_we),
        .o_arr_wline (w_arr_wline),
        .o_fill      (w_fill),
        .o_store     (w_store),
        .o_data      (o_data),
        .o_busy      (o_busy)
    );

endmodule

`default_nettype wire

// File: hdl/cache_ctrl.sv
// Cache controller
// FSM that returns hits, fills lines on read misses and merges stores
// into cached lines while the write buffer carries them to memory
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
    import mem_cache_pkg::*;
(
    input  wire               CLK,
    input  wire               i_rrst_x,
    input  wire               i_rd,
    input  wire               i_wr,
    input  wire [ADDR_W-1:0]  i_addr,
    input  wire [WORD_W-1:0]  i_wword,
    input  wire [3:0]         i_wmask,
    input  wire               i_hit,
    input  wire line_t        i_rline,
    input  wire               i_sweep,
    input  wire               i_stall,
    input  wire line_t        i_fill_line,
    output logic [ADDR_W-1:0] o_arr_addr,
    output logic              o_arr_we,
    output line_t             o_arr_wline,
    output logic              o_fill,
    output logic              o_store,
    output line_t             o_data,
    output logic              o_busy
);

    localparam int OFS_W = $clog2(LINE_BYTES);

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ,
        S_READ_MISS,
        S_WBUF_WAIT,
        S_WRITE
    } state_e;

    state_e r_state;
    state_e w_next;
    line_t  w_merged;
    line_t  w_data_nxt;
    logic   w_data_we;

    // request address stays put for the whole access
    assign o_arr_addr = i_addr;
    assign o_busy     = (r_state != S_IDLE) | i_rd | i_wr | i_sweep;

    // store word patched into the cached line
    always_comb begin
        w_merged = i_rline;
        for (int b = 0; b < 4; b++) begin
            if (i_wmask[b]) begin
                w_merged.bytes[{i_addr[OFS_W-1:2], 2'(b)}] = i_wword[8*b +: 8];
            end
        end
    end

    always_comb begin
        w_next      = r_state;
        o_fill      = 1'b0;
        o_store     = 1'b0;
        o_arr_we    = 1'b0;
        o_arr_wline = i_fill_line;
        w_data_we   = 1'b0;
        w_data_nxt  = i_rline;
        case (r_state)
            S_IDLE: begin
                if (i_wr) begin
                    if (!i_stall) begin
                        o_store = 1'b1;
                        w_next  = S_WRITE;
                    end else begin
                        w_next = S_WBUF_WAIT;         // previous store still draining
                    end
                end else if (i_rd) begin
                    w_next = S_READ;
                end
            end
            S_READ: begin
                if (i_hit) begin
                    w_data_we = 1'b1;
                    w_next    = S_IDLE;
                end else if (!i_stall) begin
                    o_fill = 1'b1;
                    w_next = S_READ_MISS;
                end
            end
            S_READ_MISS: begin
                if (!i_stall) begin                   // fill line already captured
                    o_arr_we   = 1'b1;
                    w_data_we  = 1'b1;
                    w_data_nxt = i_fill_line;
                    w_next     = S_IDLE;
                end
            end
            S_WBUF_WAIT: begin
                if (!i_stall) begin
                    o_store = 1'b1;
                    w_next  = S_WRITE;
                end
            end
            S_WRITE: begin
                if (i_hit) begin                      // miss goes to memory only
                    o_arr_we    = 1'b1;
                    o_arr_wline = w_merged;
                end
                w_next = S_IDLE;
            end
            default: w_next = S_IDLE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            r_state <= S_IDLE;
        end else begin
            r_state <= w_next;
        end
    end

    always_ff @(posedge CLK) begin
        if (w_data_we) begin
            o_data <= w_data_nxt;                     // held until the next read
        end
    end

    // each fill or store keeps the port stalled until memory is done
    a_stall_after_issue : assert property (
        @(posedge CLK) disable iff (!i_rrst_x) (o_fill || o_store) |=> i_stall
    ) else $error("memory port not stalled after a fill or store");

endmodule

`default_nettype wire

// File: hdl/mem_port.sv
// Memory-side port
// one-entry write buffer and registered read/write strobes; fills go out
// line aligned, stores word aligned, and the fill line is captured when done
`timescale 1ns/1ps
`default_nettype none

module mem_port
    import mem_cache_pkg::*;
(
    input  wire               CLK,
    input  wire               i_rrst_x,
    input  wire               i_fill,
    input  wire               i_store,
    input  wire [ADDR_W-1:0]  i_addr,
    input  wire [WORD_W-1:0]  i_wword,
    input  wire [3:0]         i_wmask,
    output logic              o_stall,
    output line_t             o_fill_line,
    output logic              o_mem_rd,
    output logic              o_mem_wr,
    output logic [ADDR_W-1:0] o_mem_addr,
    output logic [WORD_W-1:0] o_mem_wdata,
    output logic [3:0]        o_mem_mask,
    input  wire line_t        i_mem_rdata,
    input  wire               i_mem_busy
);

    localparam int OFS_W = $clog2(LINE_BYTES);

    logic r_wb_full;                                  // store held until memory is done
    logic r_pend;                                     // strobe sent, memory not finished
    logic r_is_fill;
    logic w_done;

    // memory finished once the strobe is gone and busy is low
    assign w_done  = r_pend & ~o_mem_rd & ~o_mem_wr & ~i_mem_busy;
    assign o_stall = r_wb_full | r_pend | i_mem_busy;

    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            o_mem_rd  <= 1'b0;
            o_mem_wr  <= 1'b0;
            r_pend    <= 1'b0;
            r_wb_full <= 1'b0;
        end else begin
            o_mem_rd <= i_fill;                       // one-cycle pulses
            o_mem_wr <= i_store;
            if (i_fill | i_store) begin
                r_pend <= 1'b1;
            end else if (w_done) begin
                r_pend <= 1'b0;
            end
            if (i_store) begin
                r_wb_full <= 1'b1;
            end else if (w_done) begin
                r_wb_full <= 1'b0;
            end
        end
    end

    // write buffer entry doubles as the memory-side data and mask
    always_ff @(posedge CLK) begin
        if (i_fill) begin
            o_mem_addr <= {i_addr[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
            r_is_fill  <= 1'b1;
        end else if (i_store) begin
            o_mem_addr  <= {i_addr[ADDR_W-1:2], 2'b00};
            o_mem_wdata <= i_wword;
            o_mem_mask  <= i_wmask;
            r_is_fill   <= 1'b0;
        end
        if (w_done && r_is_fill) begin
            o_fill_line <= i_mem_rdata;               // valid on first idle cycle
        end
    end

    a_one_strobe : assert property (
        @(posedge CLK) disable iff (!i_rrst_x) !(o_mem_rd && o_mem_wr)
    ) else $error("memory read and write strobes raised together");

endmodule

`default_nettype wire

// File: hdl/dcache_array.sv
// Direct-mapped cache array
// valid, tag and line in one single-port memory with a registered tag
// compare; after reset a counter walks every index and clears it
`timescale 1ns/1ps
`default_nettype none

module dcache_array
    import mem_cache_pkg::*;
#(
    parameter int CACHE_LINES = 64
) (
    input  wire              CLK,
    input  wire              i_rrst_x,
    input  wire [ADDR_W-1:0] i_addr,
    input  wire              i_we,
    input  wire line_t       i_wline,
    output line_t            o_rline,
    output logic             o_hit,
    output logic             o_sweep
);

    localparam int OFS_W = $clog2(LINE_BYTES);
    localparam int IDX_W = $clog2(CACHE_LINES);
    localparam int TAG_W = ADDR_W - IDX_W - OFS_W;
    localparam int ENT_W = 1 + TAG_W + LINE_W;       // valid, tag, line

    logic [ENT_W-1:0] mem [CACHE_LINES];

    logic [IDX_W-1:0] w_idx;
    logic [TAG_W-1:0] w_tag;
    logic [IDX_W-1:0] w_maddr;
    logic             w_mwe;
    logic [ENT_W-1:0] w_mwdata;
    logic [ENT_W-1:0] r_ent;
    logic [TAG_W-1:0] r_tag;
    logic [IDX_W-1:0] r_cnt;
    logic             w_mvalid;
    logic [TAG_W-1:0] w_mtag;

    assign w_idx = i_addr[OFS_W +: IDX_W];
    assign w_tag = i_addr[ADDR_W-1 -: TAG_W];

    // the sweep owns the port until every line is invalid
    assign w_maddr  = o_sweep ? r_cnt : w_idx;
    assign w_mwe    = o_sweep | i_we;
    assign w_mwdata = o_sweep ? '0 : {1'b1, w_tag, i_wline};

    always_ff @(posedge CLK) begin
        if (w_mwe) begin
            mem[w_maddr] <= w_mwdata;
        end
        r_ent <= mem[w_maddr];                        // old entry on a write cycle
        r_tag <= w_tag;
    end

    assign {w_mvalid, w_mtag, o_rline} = r_ent;
    assign o_hit = w_mvalid && (w_mtag == r_tag);   // tag from the previous cycle

    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            o_sweep <= 1'b1;
            r_cnt   <= '0;
        end else if (o_sweep) begin
            r_cnt <= r_cnt + 1'b1;
            if (r_cnt == IDX_W'(CACHE_LINES - 1)) begin
                o_sweep <= 1'b0;                      // last index cleared
            end
        end
    end

    // the controller holds off for the whole sweep
    a_no_write_in_sweep : assert property (
        @(posedge CLK) disable iff (!i_rrst_x) o_sweep |-> !i_we
    ) else $error("cache line written during reset sweep");

endmodule

`default_nettype wire

// File: hdl/req_latch.sv
// Request stage
// registers an accepted load/store request and turns the store size
// into a byte mask and a replicated data word
`timescale 1ns/1ps
`default_nettype none

module req_latch
    import mem_cache_pkg::*;
(
    input  wire               CLK,
    input  wire               i_rrst_x,
    input  wire               i_rd_en,
    input  wire               i_wr_en,
    input  wire [ADDR_W-1:0]  i_addr,
    input  wire [WORD_W-1:0]  i_data,
    input  wire size_e        i_size,
    input  wire               i_busy,
    output logic              o_rd,
    output logic              o_wr,
    output logic [ADDR_W-1:0] o_addr,
    output logic [WORD_W-1:0] o_wword,
    output logic [3:0]        o_wmask
);

    logic [WORD_W-1:0] r_data;
    size_e             r_size;
    logic              w_take;

    assign w_take = (i_rd_en | i_wr_en) & ~i_busy;   // accepted this edge

    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            o_rd <= 1'b0;
            o_wr <= 1'b0;
        end else begin
            o_wr <= i_wr_en & ~i_busy;               // store wins if both offered
            o_rd <= i_rd_en & ~i_wr_en & ~i_busy;
        end
    end

    always_ff @(posedge CLK) begin
        if (w_take) begin
            o_addr <= i_addr;
            r_data <= i_data;
            r_size <= i_size;
        end
    end

    // byte lanes touched by the store
    always_comb begin
        case (r_size)
            SZ_BYTE: o_wmask = 4'b0001 << o_addr[1:0];
            SZ_HALF: o_wmask = 4'b0011 << {o_addr[1], 1'b0};
            default: o_wmask = 4'b1111;
        endcase
    end

    // narrow stores go out on every lane, the mask selects the live one
    always_comb begin
        case (r_size)
            SZ_BYTE: o_wword = {4{r_data[7:0]}};
            SZ_HALF: o_wword = {2{r_data[15:0]}};
            default: o_wword = r_data;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/mem_cache_pkg.sv
// Data cache shared definitions
// bus widths, store size encoding and the two views of a cache line
`default_nettype none

package mem_cache_pkg;

    localparam int ADDR_W     = 32;            // processor byte address
    localparam int WORD_W     = 32;            // load/store data word
    localparam int LINE_W     = 128;           // one cache line
    localparam int LINE_WORDS = LINE_W / WORD_W;
    localparam int LINE_BYTES = LINE_W / 8;

    // access size of a store, as sent by the load/store unit
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } size_e;

    // a line is read out as words and patched as bytes
    typedef union packed {
        logic [LINE_WORDS-1:0][WORD_W-1:0] words;   // word lanes, word 0 at the low end
        logic [LINE_BYTES-1:0][7:0]        bytes;   // byte lanes for masked merges
    } line_t;

endpackage

`default_nettype wire
